/* verilog.f */
design/ahb_pkg.sv
design/edac_pkg.sv
design/secded_encoder.sv
design/secded_decoder.sv
design/ahb_slave_front.sv
design/edac_ram_core.sv
design/ahb_edac_ram.sv
dv/tb_ahb_edac_ram.sv

/* run_sim.sh */
#!/bin/sh
# Compile and run the EDAC RAM testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal --top-module tb_ahb_edac_ram \
    -f verilog.f -o tb_sim > build.log 2>&1 &&
    ./obj_dir/tb_sim > sim.log 2>&1 ||
    echo "Build or simulation stopped with an error, see build.log and sim.log"
grep -q "TB PASSED" sim.log && echo "Simulation passed" ||
    { echo "Simulation failed"; exit 1; }

/* dv/tb_ahb_edac_ram.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Directed testbench for the AHB-Lite EDAC RAM
// Pipelined bus transfers checked against a word reference model
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module tb_ahb_edac_ram;

    logic                  s_clk;
    logic                  s_resetn;
    logic                  s_hsel;
    ahb_pkg::haddr_t       s_haddr;
    ahb_pkg::htrans_t      s_htrans;
    logic                  s_hwrite;
    ahb_pkg::hsize_t       s_hsize;
    ahb_pkg::hdata_t       s_hwdata;
    edac_pkg::codeword_t   s_inject;
    ahb_pkg::hdata_t       s_hrdata;
    logic                  s_hready;
    logic                  s_hresp;
    edac_pkg::ecc_status_t s_status;

    // Reference words and the flip mask each one was stored with
    ahb_pkg::hdata_t       ref_mem [ahb_pkg::MEM_WORDS];
    edac_pkg::codeword_t   ref_mask [ahb_pkg::MEM_WORDS];

    // Transfer now in its data phase
    logic                  p_valid;
    logic                  p_write;
    ahb_pkg::haddr_t       p_addr;
    ahb_pkg::hsize_t       p_size;
    ahb_pkg::hdata_t       p_wdata;
    edac_pkg::codeword_t   p_mask;
    integer                seed;

    ahb_edac_ram dut0 (
        .s_clk_i    (s_clk),
        .s_resetn_i (s_resetn),
        .s_hsel_i   (s_hsel),
        .s_haddr_i  (s_haddr),
        .s_htrans_i (s_htrans),
        .s_hwrite_i (s_hwrite),
        .s_hsize_i  (s_hsize),
        .s_hwdata_i (s_hwdata),
        .s_inject_i (s_inject),
        .s_hrdata_o (s_hrdata),
        .s_hready_o (s_hready),
        .s_hresp_o  (s_hresp),
        .s_status_o (s_status)
    );

    always #4 s_clk = ~s_clk;

    task automatic check_data(input ahb_pkg::hdata_t got, input ahb_pkg::hdata_t exp,
                              input string what);
        if (got !== exp) begin
            $display("MISMATCH at %0t: %s, hrdata %h, expected %h", $time, what, got, exp);
            $display("TB FAILED");
            $fatal(1, "stopped at first error");
        end
    endtask

    task automatic check_resp(input logic resp, input logic ready, input logic exp_resp,
                              input logic exp_ready, input string what);
        if (resp !== exp_resp || ready !== exp_ready) begin
            $display("MISMATCH at %0t: %s, hresp %b hready %b, expected %b %b",
                     $time, what, resp, ready, exp_resp, exp_ready);
            $display("TB FAILED");
            $fatal(1, "stopped at first error");
        end
    endtask

    task automatic check_status(input edac_pkg::ecc_status_t got,
                                input edac_pkg::ecc_status_t exp, input string what);
        if (got !== exp) begin
            $display("MISMATCH at %0t: %s, status %b, expected %b", $time, what, got, exp);
            $display("TB FAILED");
            $fatal(1, "stopped at first error");
        end
    endtask

    // AHB lane rules for little-endian byte, halfword and word
    function automatic ahb_pkg::byte_en_t lane_enables(input ahb_pkg::haddr_t addr,
                                                       input ahb_pkg::hsize_t size);
        ahb_pkg::byte_en_t be;
        be = 4'b1111;
        if (size == 3'd0) begin
            be = '0;
            be[addr[1:0]] = 1'b1;
        end else if (size == 3'd1) begin
            be = addr[1] ? 4'b1100 : 4'b0011;
        end
        return be;
    endfunction

    function automatic edac_pkg::codeword_t flip_mask(input int pos);
        logic [edac_pkg::DATA_W+edac_pkg::ECC_W-1:0] v;
        v = '0;
        v[pos] = 1'b1;
        return edac_pkg::codeword_t'(v);
    endfunction

    task automatic wait_ready;
        int cycles;
        cycles = 0;
        while (!s_hready) begin
            cycles++;
            if (cycles > 20) begin
                $display("Timeout at %0t: hready stayed low for 20 cycles", $time);
                $display("TB FAILED");
                $fatal(1, "stopped on timeout");
            end
            @(negedge s_clk);
        end
    endtask

    // Data phase of a read, sampled mid-cycle
    task automatic finish_read;
        int w;
        int flips;
        edac_pkg::ecc_status_t exp;
        w = int'(p_addr[ahb_pkg::MEM_ADDR_W-1:2]);
        flips = $countones(ref_mask[w]);
        exp = '{corrected: (flips == 1), uncorrectable: (flips == 2)};
        check_status(s_status, exp, "read status pulse");
        if (flips == 2) begin
            check_resp(s_hresp, s_hready, 1'b1, 1'b0, "ERROR first cycle");
            check_data(s_hrdata, ref_mem[w] ^ ref_mask[w].data, "uncorrected read data");
            wait_ready();
            check_resp(s_hresp, s_hready, 1'b1, 1'b1, "ERROR second cycle");
            check_status(s_status, '0, "status after the pulse");
        end else begin
            check_resp(s_hresp, s_hready, 1'b0, 1'b1, "OKAY read");
            check_data(s_hrdata, ref_mem[w], "read data");
        end
    endtask

    // One bus cycle: new address phase plus the pending data phase
    task automatic bus_cycle(input logic act, input logic wr, input ahb_pkg::haddr_t addr,
                             input ahb_pkg::hsize_t size, input ahb_pkg::hdata_t wdata,
                             input edac_pkg::codeword_t mask);
        ahb_pkg::byte_en_t be;
        int w;
        s_hsel = act;
        s_htrans = act ? ahb_pkg::HTRANS_NONSEQ : 2'b00;
        s_haddr = addr;
        s_hwrite = wr;
        s_hsize = size;
        s_hwdata = p_wdata;
        s_inject = (p_valid && p_write) ? p_mask : '0;
        @(negedge s_clk);
        if (p_valid && !p_write) begin
            finish_read();
        end else begin
            check_resp(s_hresp, s_hready, 1'b0, 1'b1, "OKAY outside reads");
            check_status(s_status, '0, "no status pulse");
        end
        @(posedge s_clk);
        #1;
        if (p_valid && p_write) begin
            be = lane_enables(p_addr, p_size);
            w = int'(p_addr[ahb_pkg::MEM_ADDR_W-1:2]);
            for (int b = 0; b < 4; b++) begin
                if (be[b]) begin
                    ref_mem[w][8*b +: 8] = p_wdata[8*b +: 8];
                end
            end
            ref_mask[w] = p_mask;
        end
        p_valid = act;
        p_write = wr;
        p_addr = addr;
        p_size = size;
        p_wdata = wdata;
        p_mask = mask;
    endtask

    task automatic ahb_write(input ahb_pkg::haddr_t addr, input ahb_pkg::hsize_t size,
                             input ahb_pkg::hdata_t data, input edac_pkg::codeword_t mask);
        bus_cycle(1'b1, 1'b1, addr, size, data, mask);
    endtask

    task automatic ahb_read(input ahb_pkg::haddr_t addr);
        bus_cycle(1'b1, 1'b0, addr, 3'd2, '0, '0);
    endtask

    task automatic ahb_idle;
        bus_cycle(1'b0, 1'b0, '0, 3'd0, '0, '0);
    endtask

    task automatic test_word_rw;
        ahb_pkg::haddr_t addrs [8];
        for (int i = 0; i < 8; i++) begin
            addrs[i] = ahb_pkg::haddr_t'($random(seed));
            addrs[i][1:0] = 2'b00;
            ahb_write(addrs[i], 3'd2, $random(seed), '0);
        end
        for (int i = 0; i < 8; i++) begin
            ahb_read(addrs[i]);
        end
        ahb_idle();
    endtask

    task automatic test_sub_word;
        ahb_write(12'h200, 3'd2, $random(seed), '0);
        for (int off = 0; off < 4; off++) begin
            ahb_write(12'h200 + ahb_pkg::haddr_t'(off), 3'd0, $random(seed), '0);
            ahb_read(12'h200);
        end
        ahb_write(12'h204, 3'd2, $random(seed), '0);
        for (int off = 0; off < 4; off += 2) begin
            ahb_write(12'h204 + ahb_pkg::haddr_t'(off), 3'd1, $random(seed), '0);
            ahb_read(12'h204);
        end
        ahb_idle();
    endtask

    task automatic test_forwarding;
        ahb_write(12'h048, 3'd2, $random(seed), '0);
        ahb_write(12'h040, 3'd2, $random(seed), '0);
        ahb_read(12'h040);
        ahb_write(12'h044, 3'd2, $random(seed), '0);
        ahb_read(12'h048);
        ahb_read(12'h044);
        ahb_write(12'h040, 3'd2, $random(seed), '0);
        ahb_read(12'h040);
        ahb_idle();
    endtask

    task automatic test_single_inject;
        int pos [3];
        // Data bit 13, check bit 2, overall parity bit
        pos = '{20, 2, 6};
        for (int i = 0; i < 3; i++) begin
            ahb_write(12'h300 + ahb_pkg::haddr_t'(4 * i), 3'd2, $random(seed), flip_mask(pos[i]));
            ahb_read(12'h300 + ahb_pkg::haddr_t'(4 * i));
        end
        // Byte store rewrites the whole word clean
        ahb_write(12'h301, 3'd0, $random(seed), '0);
        ahb_read(12'h300);
        ahb_idle();
    endtask

    task automatic test_double_inject;
        ahb_write(12'h3f0, 3'd2, $random(seed), '0);
        ahb_write(12'h3f4, 3'd2, $random(seed), flip_mask(10) ^ flip_mask(30));
        ahb_read(12'h3f4);
        ahb_read(12'h3f0);
        ahb_write(12'h3f8, 3'd2, $random(seed), flip_mask(1) ^ flip_mask(25));
        ahb_read(12'h3f8);
        ahb_idle();
        ahb_read(12'h3f0);
        ahb_idle();
    endtask

    initial begin
        seed = 32'hb11a_f66f;
        s_clk = 1'b0;
        s_resetn = 1'b0;
        s_hsel = 1'b0;
        s_haddr = '0;
        s_htrans = '0;
        s_hwrite = 1'b0;
        s_hsize = '0;
        s_hwdata = '0;
        s_inject = '0;
        p_valid = 1'b0;
        p_write = 1'b0;
        p_addr = '0;
        p_size = '0;
        p_wdata = '0;
        p_mask = '0;
        for (int i = 0; i < ahb_pkg::MEM_WORDS; i++) begin
            ref_mem[i] = '0;
            ref_mask[i] = '0;
        end
        repeat (8) @(posedge s_clk);
        #1;
        s_resetn = 1'b1;
        ahb_idle();
        test_word_rw();
        test_sub_word();
        test_forwarding();
        test_single_inject();
        test_double_inject();
        $display("TB PASSED");
        $finish;
    end

endmodule

/* design/ahb_edac_ram.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// 4 KiB AHB-Lite RAM with SEC-DED protection and error injection
// Top level, ties the bus front, storage core and decoder together
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module ahb_edac_ram (
    input  logic                  s_clk_i,
    input  logic                  s_resetn_i,
    input  logic                  s_hsel_i,
    input  ahb_pkg::haddr_t       s_haddr_i,
    input  ahb_pkg::htrans_t      s_htrans_i,
    input  logic                  s_hwrite_i,
    input  ahb_pkg::hsize_t       s_hsize_i,
    input  ahb_pkg::hdata_t       s_hwdata_i,
    input  edac_pkg::codeword_t   s_inject_i,
    output ahb_pkg::hdata_t       s_hrdata_o,
    output logic                  s_hready_o,
    output logic                  s_hresp_o,
    output edac_pkg::ecc_status_t s_status_o
);

    ahb_pkg::ahb_xfer_t    s_addr_xfer;
    ahb_pkg::ahb_xfer_t    s_data_xfer;
    edac_pkg::codeword_t   s_raw_word;
    edac_pkg::ecc_status_t s_dec_status;

    ahb_slave_front front0 (
        .s_clk_i       (s_clk_i),
        .s_resetn_i    (s_resetn_i),
        .s_hsel_i      (s_hsel_i),
        .s_haddr_i     (s_haddr_i),
        .s_htrans_i    (s_htrans_i),
        .s_hwrite_i    (s_hwrite_i),
        .s_hsize_i     (s_hsize_i),
        .s_status_i    (s_dec_status),
        .s_addr_xfer_o (s_addr_xfer),
        .s_data_xfer_o (s_data_xfer),
        .s_hready_o    (s_hready_o),
        .s_hresp_o     (s_hresp_o),
        .s_status_o    (s_status_o)
    );

    // Corrected data is both the read result and the merge base
    edac_ram_core core0 (
        .s_clk_i        (s_clk_i),
        .s_resetn_i     (s_resetn_i),
        .s_addr_xfer_i  (s_addr_xfer),
        .s_data_xfer_i  (s_data_xfer),
        .s_hwdata_i     (s_hwdata_i),
        .s_inject_i     (s_inject_i),
        .s_fixed_data_i (s_hrdata_o),
        .s_raw_word_o   (s_raw_word)
    );

    secded_decoder dec0 (
        .s_raw_word_i   (s_raw_word),
        .s_fixed_data_o (s_hrdata_o),
        .s_status_o     (s_dec_status)
    );

endmodule

/* design/edac_ram_core.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Codeword storage of the EDAC RAM
// Read in the address phase, read-modify-write in the data phase
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module edac_ram_core (
    input  logic                s_clk_i,
    input  logic                s_resetn_i,
    input  ahb_pkg::ahb_xfer_t  s_addr_xfer_i,
    input  ahb_pkg::ahb_xfer_t  s_data_xfer_i,
    input  ahb_pkg::hdata_t     s_hwdata_i,
    input  edac_pkg::codeword_t s_inject_i,
    input  ahb_pkg::hdata_t     s_fixed_data_i,
    output edac_pkg::codeword_t s_raw_word_o
);

    edac_pkg::codeword_t r_mem [ahb_pkg::MEM_WORDS];
    edac_pkg::codeword_t s_store_word;
    edac_pkg::ecc_t      s_new_ecc;
    ahb_pkg::hdata_t     s_merged;
    logic                s_wr_en;
    logic                s_fwd;

    assign s_wr_en = s_data_xfer_i.valid && s_data_xfer_i.write;

    // Unselected lanes keep the corrected old contents
    always_comb begin
        for (int b = 0; b < 4; b++) begin
            s_merged[8*b +: 8] = s_data_xfer_i.be[b] ? s_hwdata_i[8*b +: 8] :
                                                        s_fixed_data_i[8*b +: 8];
        end
    end

    secded_encoder enc0 (
        .s_data_i (s_merged),
        .s_ecc_o  (s_new_ecc)
    );

    // Flip mask lands in the stored word as-is
    assign s_store_word = {s_merged, s_new_ecc} ^ s_inject_i;

    always_ff @(posedge s_clk_i) begin
        if (s_wr_en) begin
            r_mem[s_data_xfer_i.addr] <= s_store_word;
        end
    end

    // Array read would return the old word on a same-edge write
    assign s_fwd = s_wr_en && (s_data_xfer_i.addr == s_addr_xfer_i.addr);

    always_ff @(posedge s_clk_i) begin
        if (s_fwd) begin
            s_raw_word_o <= s_store_word;
        end else begin
            s_raw_word_o <= r_mem[s_addr_xfer_i.addr];
        end
    end

    // Commit needs a write accepted by the front one cycle before
    a_write_accepted: assert property (@(posedge s_clk_i) disable iff (!s_resetn_i)
        s_wr_en |-> $past(s_addr_xfer_i.valid && s_addr_xfer_i.write));

endmodule

/* design/ahb_slave_front.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// AHB-Lite slave front end of the EDAC RAM
// Captures address phases, answers with OKAY or the two-cycle ERROR
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module ahb_slave_front (
    input  logic                  s_clk_i,
    input  logic                  s_resetn_i,
    input  logic                  s_hsel_i,
    input  ahb_pkg::haddr_t       s_haddr_i,
    input  ahb_pkg::htrans_t      s_htrans_i,
    input  logic                  s_hwrite_i,
    input  ahb_pkg::hsize_t       s_hsize_i,
    input  edac_pkg::ecc_status_t s_status_i,
    output ahb_pkg::ahb_xfer_t    s_addr_xfer_o,
    output ahb_pkg::ahb_xfer_t    s_data_xfer_o,
    output logic                  s_hready_o,
    output logic                  s_hresp_o,
    output edac_pkg::ecc_status_t s_status_o
);

    ahb_pkg::front_state_t r_state;
    ahb_pkg::front_state_t s_state;
    ahb_pkg::front_state_t s_next_state;
    ahb_pkg::byte_en_t     s_byte_en;
    logic                  s_active;
    logic                  s_read_dp;

    assign s_active = (s_htrans_i == ahb_pkg::HTRANS_NONSEQ) ||
                      (s_htrans_i == ahb_pkg::HTRANS_SEQ);

    // Lane select from size and low address bits
    always_comb begin
        case (s_hsize_i)
            3'd0:    s_byte_en = 4'b0001 << s_haddr_i[1:0];
            3'd1:    s_byte_en = s_haddr_i[1] ? 4'b1100 : 4'b0011;
            default: s_byte_en = 4'b1111;
        endcase
    end

    // Not valid while hready is low, the master holds it for later
    assign s_addr_xfer_o = '{
        addr:  s_haddr_i[ahb_pkg::MEM_ADDR_W-1:2],
        be:    s_byte_en,
        write: s_hwrite_i,
        valid: s_hready_o && s_hsel_i && s_active
    };

    // First cycle of a read data phase, flags only count here
    assign s_read_dp = s_data_xfer_o.valid && !s_data_xfer_o.write &&
                       (r_state == ahb_pkg::OKAY_PHASE);
    assign s_status_o = s_read_dp ? s_status_i : '0;

    // ERR_FIRST is entered in the very cycle the bad word shows up
    assign s_state = (s_read_dp && s_status_i.uncorrectable) ? ahb_pkg::ERR_FIRST : r_state;

    always_comb begin
        case (s_state)
            ahb_pkg::ERR_FIRST: s_next_state = ahb_pkg::ERR_SECOND;
            default:            s_next_state = ahb_pkg::OKAY_PHASE;
        endcase
    end

    assign s_hready_o = (s_state != ahb_pkg::ERR_FIRST);
    assign s_hresp_o = (s_state != ahb_pkg::OKAY_PHASE);

    always_ff @(posedge s_clk_i) begin
        if (!s_resetn_i) begin
            r_state <= ahb_pkg::OKAY_PHASE;
            s_data_xfer_o <= '0;
        end else begin
            r_state <= s_next_state;
            // Data phase advances only when the current one completes
            if (s_hready_o) begin
                s_data_xfer_o <= s_addr_xfer_o;
            end
        end
    end

    // ERROR response is always the full two-cycle sequence
    a_hresp_err_only: assert property (@(posedge s_clk_i) disable iff (!s_resetn_i)
        s_hresp_o |-> (s_state == ahb_pkg::ERR_FIRST) ||
                      (s_state == ahb_pkg::ERR_SECOND && $past(s_state == ahb_pkg::ERR_FIRST)));

    a_wait_first_only: assert property (@(posedge s_clk_i) disable iff (!s_resetn_i)
        !s_hready_o |-> (s_state == ahb_pkg::ERR_FIRST) ##1 (s_hready_o && s_hresp_o));

endmodule

/* design/secded_decoder.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// SEC-DED check of a stored codeword
// Gives corrected data and the error class, combinational
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module secded_decoder (
    input  edac_pkg::codeword_t   s_raw_word_i,
    output ahb_pkg::hdata_t       s_fixed_data_o,
    output edac_pkg::ecc_status_t s_status_o
);

    edac_pkg::ecc_t      s_recalc;
    edac_pkg::ecc_t      s_diff;
    edac_pkg::syndrome_t s_syndrome;
    logic                s_parity_bad;

    secded_encoder enc0 (
        .s_data_i (s_raw_word_i.data),
        .s_ecc_o  (s_recalc)
    );

    assign s_diff = s_recalc ^ s_raw_word_i.ecc;
    assign s_syndrome = s_diff[edac_pkg::ECC_W-2:0];

    // XOR of the whole difference equals parity over all 39 stored bits
    assign s_parity_bad = ^s_diff;

    // Odd parity means one flipped bit, fix it if it is a data bit
    always_comb begin : correct
        s_fixed_data_o = s_raw_word_i.data;
        if (s_parity_bad) begin
            for (int i = 0; i < edac_pkg::DATA_W; i++) begin
                if (edac_pkg::data_pos(i) == s_syndrome) begin
                    s_fixed_data_o[i] = ~s_raw_word_i.data[i];
                end
            end
        end
    end

    // Even parity with a nonzero syndrome is a double error
    assign s_status_o = '{
        corrected:     s_parity_bad,
        uncorrectable: !s_parity_bad && (s_syndrome != '0)
    };

endmodule

/* design/secded_encoder.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Extended Hamming check field of a 32-bit word
// Purely combinational, used on the write path and in the decoder
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module secded_encoder (
    input  ahb_pkg::hdata_t s_data_i,
    output edac_pkg::ecc_t  s_ecc_o
);

    edac_pkg::syndrome_t s_hamming;

    // Check bit k covers every position with bit k of its index set
    always_comb begin : parity_tree
        edac_pkg::syndrome_t pos;
        s_hamming = '0;
        for (int i = 0; i < edac_pkg::DATA_W; i++) begin
            pos = edac_pkg::data_pos(i);
            for (int k = 0; k < edac_pkg::ECC_W - 1; k++) begin
                if (pos[k]) begin
                    s_hamming[k] = s_hamming[k] ^ s_data_i[i];
                end
            end
        end
    end

    // Overall parity over data and the six Hamming bits
    assign s_ecc_o = {^{s_data_i, s_hamming}, s_hamming};

endmodule

/* design/edac_pkg.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// SEC-DED code definitions shared by encoder, decoder and core
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
package edac_pkg;

    localparam int unsigned DATA_W = 32;
    localparam int unsigned ECC_W = 7;

    typedef logic [ECC_W-1:0] ecc_t;
    // Hamming position of a bit, also the syndrome value
    typedef logic [ECC_W-2:0] syndrome_t;

    // Stored word, doubles as the injection flip mask
    typedef struct packed {
        logic [DATA_W-1:0] data;
        ecc_t              ecc;
    } codeword_t;

    typedef struct packed {
        logic corrected;
        logic uncorrectable;
    } ecc_status_t;

    // Data bit idx sits at the idx-th non-power-of-two position from 3
    function automatic syndrome_t data_pos(input int idx);
        int cnt;
        syndrome_t pos;
        cnt = 0;
        pos = '0;
        for (int p = 3; p < DATA_W + ECC_W; p++) begin
            if ((p & (p - 1)) != 0) begin
                if (cnt == idx) begin
                    pos = syndrome_t'(p);
                end
                cnt++;
            end
        end
        return pos;
    endfunction

endpackage

/* design/ahb_pkg.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// AHB-Lite side definitions for the EDAC RAM slave
// Bus widths, transfer codes and the captured-transfer record
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
package ahb_pkg;

    // 4 KiB byte address space
    localparam int unsigned MEM_ADDR_W = 12;
    localparam int unsigned WORD_ADDR_W = MEM_ADDR_W - 2;
    localparam int unsigned MEM_WORDS = 1 << WORD_ADDR_W;

    typedef logic [MEM_ADDR_W-1:0] haddr_t;
    typedef logic [WORD_ADDR_W-1:0] word_addr_t;
    typedef logic [31:0] hdata_t;
    typedef logic [1:0] htrans_t;
    typedef logic [2:0] hsize_t;
    typedef logic [3:0] byte_en_t;

    // Only the active codes matter here, IDLE and BUSY are ignored
    localparam htrans_t HTRANS_NONSEQ = 2'b10;
    localparam htrans_t HTRANS_SEQ = 2'b11;

    typedef struct packed {
        word_addr_t addr;
        byte_en_t   be;
        logic       write;
        logic       valid;
    } ahb_xfer_t;

    // ERR_FIRST is the wait cycle of the error response
    typedef enum logic [1:0] {
        OKAY_PHASE,
        ERR_FIRST,
        ERR_SECOND
    } front_state_t;

endpackage
